/* hw/chan_sum_pkg.sv */
package chan_sum_pkg;

  //////////////////////////////////////////////////
  // Sizes

  // Pixel width in bits
  localparam int DATA_WIDTH = 16;

  // Channels summed per pixel, power of two
  localparam int CHANNELS = 4;

  // Samples in one channel frame
  localparam int FRAME_PIXELS = 16;

  // One adder level per halving of the channel count
  localparam int TREE_LEVELS = $clog2(CHANNELS);

  // One extra bit per level, so the sum never wraps
  localparam int SUM_WIDTH = DATA_WIDTH + TREE_LEVELS;

  localparam int PIX_CNT_WIDTH  = $clog2(FRAME_PIXELS);
  localparam int CHAN_CNT_WIDTH = $clog2(CHANNELS);

  //////////////////////////////////////////////////
  // Types

  typedef logic signed [DATA_WIDTH-1:0] pixel_t;
  typedef logic signed [SUM_WIDTH-1:0]  sum_t;

  // Input stream beat, also what each delay line hands on
  typedef struct packed {
    logic   valid;
    pixel_t pixel;
  } pixel_beat_t;

  // Same pixel position across all channels
  // pix[0] is the newest channel, pix[CHANNELS-1] the oldest
  typedef struct packed {
    logic                  valid;
    logic                  sum_en;
    pixel_t [CHANNELS-1:0] pix;
  } tap_set_t;

  // Output stream beat
  typedef struct packed {
    logic valid;
    sum_t sum;
  } sum_beat_t;

endpackage

/* hw/frame_delay_line.sv */
module frame_delay_line (
  input  logic                      clk,
  input  logic                      reset,
  input  chan_sum_pkg::pixel_beat_t din,
  output chan_sum_pkg::pixel_beat_t dout
);

  //////////////////////////////////////////////////
  // Storage

  // Ring of one full frame, no reset on the data
  chan_sum_pkg::pixel_t mem [chan_sum_pkg::FRAME_PIXELS];

  logic [chan_sum_pkg::PIX_CNT_WIDTH-1:0] wr_ptr;
  logic                                   ptr_last;

  assign ptr_last = (wr_ptr == chan_sum_pkg::PIX_CNT_WIDTH'(chan_sum_pkg::FRAME_PIXELS - 1));

  //////////////////////////////////////////////////
  // Read side

  // Oldest entry sits where the next write lands
  assign dout.pixel = mem[wr_ptr];

  // Strobe passes straight through, so the chain stays in step
  assign dout.valid = din.valid;

  //////////////////////////////////////////////////
  // Write side

  always_ff @(posedge clk) begin
    if (reset) begin
      wr_ptr <= '0;
    end else if (din.valid) begin
      if (ptr_last) begin
        wr_ptr <= '0;
      end else begin
        wr_ptr <= wr_ptr + 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (din.valid) begin
      mem[wr_ptr] <= din.pixel;
    end
  end

  //////////////////////////////////////////////////
  // Checks

  // Pointer must stay inside the frame, whatever the frame size
  ptr_in_range: assert property (
    @(posedge clk) disable iff (reset)
      wr_ptr < chan_sum_pkg::FRAME_PIXELS
  ) else $error("delay line pointer out of range: %0d", wr_ptr);

endmodule

/* hw/channel_tracker.sv */
module channel_tracker (
  input  logic clk,
  input  logic reset,
  input  logic pix_valid,
  output logic sum_en
);

  //////////////////////////////////////////////////
  // Counters

  // Position inside the current frame
  logic [chan_sum_pkg::PIX_CNT_WIDTH-1:0]  pix_cnt;
  // Which channel frame is streaming now
  logic [chan_sum_pkg::CHAN_CNT_WIDTH-1:0] chan_cnt;

  logic pix_last;
  logic chan_last;

  assign pix_last  = (pix_cnt == chan_sum_pkg::PIX_CNT_WIDTH'(chan_sum_pkg::FRAME_PIXELS - 1));
  assign chan_last = (chan_cnt == chan_sum_pkg::CHAN_CNT_WIDTH'(chan_sum_pkg::CHANNELS - 1));

  // Only valid samples move the counters and gaps just hold them
  always_ff @(posedge clk) begin
    if (reset) begin
      pix_cnt  <= '0;
      chan_cnt <= '0;
    end else if (pix_valid) begin
      if (pix_last) begin
        pix_cnt <= '0;
        // Frame done so step to next channel or back to channel 0
        if (chan_last) begin
          chan_cnt <= '0;
        end else begin
          chan_cnt <= chan_cnt + 1'b1;
        end
      end else begin
        pix_cnt <= pix_cnt + 1'b1;
      end
    end
  end

  //////////////////////////////////////////////////
  // Sum enable

  // Whole last-channel frame is summed
  // Every older channel already sits in the delay lines by then
  assign sum_en = chan_last;

  //////////////////////////////////////////////////
  // Checks

  chan_in_range: assert property (
    @(posedge clk) disable iff (reset)
      chan_cnt <= chan_sum_pkg::CHANNELS - 1
  ) else $error("channel count out of range: %0d", chan_cnt);

endmodule

/* hw/channel_adder_tree.sv */
module channel_adder_tree (
  input  logic                   clk,
  input  logic                   reset,
  input  chan_sum_pkg::tap_set_t taps,
  output chan_sum_pkg::sum_beat_t sum_out
);

  //////////////////////////////////////////////////
  // Tree layout

  // Heap order with node 1 as the root
  // Nodes CHANNELS/2 .. CHANNELS-1 form the first level and take the taps
  // Node n below that adds nodes 2n and 2n+1
  // All nodes carry the full result width
  // Upper bits of the lower levels are plain sign copies
  chan_sum_pkg::sum_t node_q [1:chan_sum_pkg::CHANNELS-1];

  // One valid per level with bit 0 as the first level
  logic [chan_sum_pkg::TREE_LEVELS-1:0] vld_q;

  logic accept;

  assign accept = taps.valid & taps.sum_en;

  //////////////////////////////////////////////////
  // Valid pipeline

  always_ff @(posedge clk) begin
    if (reset) begin
      vld_q <= '0;
    end else begin
      vld_q[0] <= accept;
      for (int l = 1; l < chan_sum_pkg::TREE_LEVELS; l++) begin
        vld_q[l] <= vld_q[l-1];
      end
    end
  end

  //////////////////////////////////////////////////
  // Adder nodes

  for (genvar n = 1; n < chan_sum_pkg::CHANNELS; n++) begin : g_node
    if (n >= chan_sum_pkg::CHANNELS / 2) begin : g_first
      // Sign-extend each tap pair before adding
      always_ff @(posedge clk) begin
        if (accept) begin
          node_q[n] <=
            chan_sum_pkg::sum_t'(taps.pix[2*(n - chan_sum_pkg::CHANNELS/2)]) +
            chan_sum_pkg::sum_t'(taps.pix[2*(n - chan_sum_pkg::CHANNELS/2) + 1]);
        end
      end
    end else begin : g_inner
      // Children sit one level closer to the taps
      always_ff @(posedge clk) begin
        if (vld_q[chan_sum_pkg::TREE_LEVELS - $clog2(n + 1) - 1]) begin
          node_q[n] <= node_q[2*n] + node_q[2*n + 1];
        end
      end
    end
  end

  //////////////////////////////////////////////////
  // Output

  assign sum_out.valid = vld_q[chan_sum_pkg::TREE_LEVELS-1];
  assign sum_out.sum   = node_q[1];

  //////////////////////////////////////////////////
  // Checks

  // Catches a sum built from delay-line entries never written
  sum_known: assert property (
    @(posedge clk) disable iff (reset)
      sum_out.valid |-> !$isunknown(sum_out.sum)
  ) else $error("output valid with unknown sum bits");

endmodule

/* hw/channel_sum_top.sv */
module channel_sum_top (
  input  logic                      clk,
  input  logic                      reset,
  input  chan_sum_pkg::pixel_beat_t pix_in,
  output chan_sum_pkg::sum_beat_t   sum_out
);

  //////////////////////////////////////////////////
  // Delay chain

  // line[0] is the live input, line[k+1] is delay line k output
  // so line[k] holds the same pixel position k frames back
  chan_sum_pkg::pixel_beat_t line [chan_sum_pkg::CHANNELS];

  logic                   sum_en;
  chan_sum_pkg::tap_set_t tap_set;

  assign line[0] = pix_in;

  for (genvar k = 0; k < chan_sum_pkg::CHANNELS - 1; k++) begin : g_delay
    frame_delay_line u_delay (
      .clk   (clk),
      .reset (reset),
      .din   (line[k]),
      .dout  (line[k+1])
    );
  end

  //////////////////////////////////////////////////
  // Channel tracking

  channel_tracker u_tracker (
    .clk       (clk),
    .reset     (reset),
    .pix_valid (pix_in.valid),
    .sum_en    (sum_en)
  );

  //////////////////////////////////////////////////
  // Tap bundle

  // Strobe runs through the chain unchanged, the end of it is the input valid
  assign tap_set.valid  = line[chan_sum_pkg::CHANNELS-1].valid;
  assign tap_set.sum_en = sum_en;

  for (genvar k = 0; k < chan_sum_pkg::CHANNELS; k++) begin : g_tap
    assign tap_set.pix[k] = line[k].pixel;
  end

  //////////////////////////////////////////////////
  // Adder tree

  channel_adder_tree u_tree (
    .clk     (clk),
    .reset   (reset),
    .taps    (tap_set),
    .sum_out (sum_out)
  );

endmodule

/* testbench/tb_channel_sum_tasks.svh */
//////////////////////////////////////////////////
// Stimulus

// Drop valid for n cycles
task automatic idle_cycles(input int n);
  for (int i = 0; i < n; i++) begin
    @(negedge clk);
    pix_in.valid = 1'b0;
    pix_in.pixel = '0;
  end
endtask

task automatic drive_sample(input chan_sum_pkg::pixel_t value);
  @(negedge clk);
  pix_in.valid = 1'b1;
  pix_in.pixel = value;
endtask

task automatic fill_random();
  for (int c = 0; c < chan_sum_pkg::CHANNELS; c++) begin
    for (int p = 0; p < chan_sum_pkg::FRAME_PIXELS; p++) begin
      img[c][p] = chan_sum_pkg::pixel_t'($random(seed));
    end
  end
endtask

task automatic fill_const(input chan_sum_pkg::pixel_t value);
  for (int c = 0; c < chan_sum_pkg::CHANNELS; c++) begin
    for (int p = 0; p < chan_sum_pkg::FRAME_PIXELS; p++) begin
      img[c][p] = value;
    end
  end
endtask

// Plain sum over all channels at one pixel index in the widened type
function automatic chan_sum_pkg::sum_t ref_sum(input int p);
  chan_sum_pkg::sum_t acc;
  acc = '0;
  for (int c = 0; c < chan_sum_pkg::CHANNELS; c++) begin
    acc = acc + chan_sum_pkg::sum_t'(img[c][p]);
  end
  return acc;
endfunction

// Streams the first n_pix samples of one channel frame
// gap_pct is the chance in percent of 1 to 4 idle cycles before a sample
task automatic send_frame(input int ch, input int n_pix, input int gap_pct);
  int r;
  int gap_len;
  for (int p = 0; p < n_pix; p++) begin
    r = $random(seed);
    if (((r & 32'h7fff_ffff) % 100) < gap_pct) begin
      gap_len = 1 + ((r >> 8) & 3);
      idle_cycles(gap_len);
    end
    drive_sample(img[ch][p]);
    // Sum of a last channel sample comes out two cycles later
    if (ch == chan_sum_pkg::CHANNELS - 1) begin
      exp_sum.push_back(ref_sum(p));
      exp_cycle.push_back(cycle_cnt + 2);
      exp_pix.push_back(p);
    end
  end
endtask

task automatic send_image(input int gap_pct);
  for (int c = 0; c < chan_sum_pkg::CHANNELS; c++) begin
    send_frame(c, chan_sum_pkg::FRAME_PIXELS, gap_pct);
  end
endtask

// Clears the scoreboard while reset is held
task automatic apply_reset(input int cycles);
  @(negedge clk);
  reset        = 1'b1;
  pix_in.valid = 1'b0;
  pix_in.pixel = '0;
  repeat (cycles) @(negedge clk);
  exp_sum.delete();
  exp_cycle.delete();
  exp_pix.delete();
  obs_sum.delete();
  obs_cycle.delete();
  reset = 1'b0;
endtask

//////////////////////////////////////////////////
// Result checking

task automatic wait_sum(output chan_sum_pkg::sum_t value, output int cycle);
  int waited;
  waited = 0;
  while (obs_sum.size() == 0) begin
    if (waited >= SUM_TIMEOUT) begin
      report_failure($sformatf("no result arrived within %0d cycles", SUM_TIMEOUT));
    end
    @(negedge clk);
    waited++;
  end
  value = obs_sum.pop_front();
  cycle = obs_cycle.pop_front();
endtask

task automatic check_sum(input chan_sum_pkg::sum_t got, input chan_sum_pkg::sum_t exp,
                         input string what);
  if (got !== exp) begin
    value_mismatch($sformatf("%s sum is %0d, expected %0d", what, got, exp));
  end
endtask

// Matches every expected result in order, then makes sure no extra one follows
task automatic drain_results();
  chan_sum_pkg::sum_t exp_val;
  chan_sum_pkg::sum_t got_val;
  int                 exp_cyc;
  int                 got_cyc;
  int                 pix;
  idle_cycles(1);
  while (exp_sum.size() > 0) begin
    exp_val = exp_sum.pop_front();
    exp_cyc = exp_cycle.pop_front();
    pix     = exp_pix.pop_front();
    wait_sum(got_val, got_cyc);
    check_sum(got_val, exp_val, $sformatf("pixel %0d", pix));
    if (got_cyc != exp_cyc) begin
      value_mismatch($sformatf("pixel %0d result in cycle %0d, expected cycle %0d",
                               pix, got_cyc, exp_cyc));
    end
  end
  idle_cycles(4);
  if (obs_sum.size() != 0) begin
    report_failure("the DUT produced more results than pixels sent");
  end
endtask

/* testbench/tb_channel_sum.sv */
module tb_channel_sum;

  //////////////////////////////////////////////////
  // Testbench constants

  // Longest wait for one result, in clock cycles
  localparam int SUM_TIMEOUT = 64;

  localparam chan_sum_pkg::pixel_t PIX_MAX =
    chan_sum_pkg::pixel_t'({1'b0, {(chan_sum_pkg::DATA_WIDTH-1){1'b1}}});
  localparam chan_sum_pkg::pixel_t PIX_MIN =
    chan_sum_pkg::pixel_t'({1'b1, {(chan_sum_pkg::DATA_WIDTH-1){1'b0}}});

  //////////////////////////////////////////////////
  // Clock, reset and DUT

  logic clk = 1'b0;
  logic reset;

  chan_sum_pkg::pixel_beat_t pix_in;
  chan_sum_pkg::sum_beat_t   sum_out;

  always #10 clk = ~clk;

  channel_sum_top dut0 (
    .clk     (clk),
    .reset   (reset),
    .pix_in  (pix_in),
    .sum_out (sum_out)
  );

  //////////////////////////////////////////////////
  // Scoreboard state

  int seed;
  int cycle_cnt = 0;

  // Image currently being streamed, [channel][pixel]
  chan_sum_pkg::pixel_t img [chan_sum_pkg::CHANNELS][chan_sum_pkg::FRAME_PIXELS];

  // Expected results in arrival order
  chan_sum_pkg::sum_t exp_sum [$];
  int                 exp_cycle [$];
  int                 exp_pix [$];

  // Results seen on sum_out
  chan_sum_pkg::sum_t obs_sum [$];
  int                 obs_cycle [$];

  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
  end

  // Outputs only move on the rising edge, so sample them half a cycle later
  always @(negedge clk) begin
    if (reset === 1'b0 && sum_out.valid === 1'b1) begin
      obs_sum.push_back(sum_out.sum);
      obs_cycle.push_back(cycle_cnt);
    end
  end

  //////////////////////////////////////////////////
  // Error handling

  task automatic abort_run();
    $display("Simulation failed");
    $fatal(1, "stopped at first error");
  endtask

  task automatic value_mismatch(input string msg);
    $display("mismatch at time %0t: %s", $time, msg);
    abort_run();
  endtask

  task automatic report_failure(input string msg);
    $display("error at time %0t: %s", $time, msg);
    abort_run();
  endtask

  `include "tb_channel_sum_tasks.svh"

  //////////////////////////////////////////////////
  // Directed tests

  // Nothing may come out before the last channel frame starts
  task automatic test_quiet_until_last_channel();
    $display("running: quiet until last channel");
    fill_random();
    for (int c = 0; c < chan_sum_pkg::CHANNELS - 1; c++) begin
      send_frame(c, chan_sum_pkg::FRAME_PIXELS, 0);
    end
    idle_cycles(4);
    if (obs_sum.size() != 0) begin
      report_failure("a result came out before the last channel frame");
    end
    send_frame(chan_sum_pkg::CHANNELS - 1, chan_sum_pkg::FRAME_PIXELS, 0);
    drain_results();
  endtask

  task automatic test_contiguous_image();
    $display("running: contiguous image");
    fill_random();
    send_image(0);
    drain_results();
  endtask

  // Same image twice, once without and once with gaps
  task automatic test_gapped_image();
    $display("running: gapped image");
    fill_random();
    send_image(0);
    drain_results();
    send_image(40);
    drain_results();
  endtask

  task automatic test_extreme_pixels();
    $display("running: extreme pixels");
    fill_const(PIX_MAX);
    send_image(0);
    drain_results();
    fill_const(PIX_MIN);
    send_image(0);
    drain_results();
  endtask

  // Counters and pointers have to wrap cleanly between images
  task automatic test_back_to_back();
    $display("running: back to back images");
    for (int i = 0; i < 3; i++) begin
      fill_random();
      send_image(0);
    end
    drain_results();
  endtask

  task automatic test_reset_mid_image();
    $display("running: reset in mid image");
    fill_random();
    send_frame(0, chan_sum_pkg::FRAME_PIXELS, 0);
    send_frame(1, chan_sum_pkg::FRAME_PIXELS, 0);
    send_frame(2, chan_sum_pkg::FRAME_PIXELS / 2, 0);
    apply_reset(4);
    fill_random();
    send_image(0);
    drain_results();
  endtask

  //////////////////////////////////////////////////
  // Main sequence

  initial begin
    seed   = 32'hca3d_0f8e;
    reset  = 1'b1;
    pix_in = '0;
    repeat (8) @(negedge clk);
    reset = 1'b0;

    test_quiet_until_last_channel();
    test_contiguous_image();
    test_gapped_image();
    test_extreme_pixels();
    test_back_to_back();
    test_reset_mid_image();

    idle_cycles(4);
    if (obs_sum.size() != 0 || exp_sum.size() != 0) begin
      report_failure("results left over at the end of the run");
    end else begin
      $display("Simulation passed");
      $finish;
    end
  end

endmodule

/* files.f */
+incdir+testbench
hw/chan_sum_pkg.sv
hw/frame_delay_line.sv
hw/channel_tracker.sv
hw/channel_adder_tree.sv
hw/channel_sum_top.sv
testbench/tb_channel_sum.sv

/* run_sim.sh */
#!/bin/sh
# Compile with Verilator, run, and decide from the simulation log

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_channel_sum -f files.f > build.log 2>&1 \
  || { echo "Verilator build failed, see build.log"; exit 1; }

./obj_dir/Vtb_channel_sum > sim.log 2>&1

grep -q "^Simulation passed$" sim.log \
  && echo "PASS" \
  || { echo "FAIL, see sim.log"; exit 1; }
